// ==== rtl/axi_image_bridge_pkg.sv ====
package axi_image_bridge_pkg;

    localparam int AXI_ADDR_WIDTH = 7;
    localparam int AXI_DATA_WIDTH = 128;
    localparam int AXI_ID_WIDTH   = 16;
    localparam int AXI_LEN_WIDTH  = 8;

    // Field positions inside the image size word
    localparam int SIZE_WIDTH_LSB  = 32;
    localparam int SIZE_HEIGHT_LSB = 0;

    typedef enum logic [1:0] {
        resp_okay   = 2'd0,
        resp_slverr = 2'd2
    } axi_resp_e;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        reg_fifo_data   = 7'h00,
        reg_fifo_flush  = 7'h10,
        reg_image_size  = 7'h20,
        reg_dram_done   = 7'h30,
        reg_dram_buffer = 7'h40,
        reg_new_image   = 7'h50,
        reg_irq_clear   = 7'h60
    } wr_reg_e;

    typedef enum logic [6:0] {
        reg_dram_request = 7'h00,
        reg_resolution   = 7'h10
    } rd_reg_e;

    ////////////////////////////////////////////////////////////
    // Controller states
    ////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        wr_idle, wr_fifo, wr_flush, wr_size, wr_buffer,
        wr_done, wr_new_image, wr_irq_clear, wr_drain, wr_resp
    } write_state_e;

    typedef enum logic [1:0] {
        rd_idle, rd_request, rd_resolution, rd_error
    } read_state_e;

endpackage

// ==== rtl/write_ctrl.sv ====
`timescale 1ns/1ns

module write_ctrl #(
    parameter int width_bits  = 12,
    parameter int height_bits = 11
) (
    input  logic                                            s_axi_aclk,
    input  logic                                            s_axi_aresetn,
    input  logic [axi_image_bridge_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic [axi_image_bridge_pkg::AXI_ID_WIDTH-1:0]   awid,
    input  logic [axi_image_bridge_pkg::AXI_LEN_WIDTH-1:0]  awlen,
    input  logic                                            awvalid,
    output logic                                            awready,
    input  logic [axi_image_bridge_pkg::AXI_DATA_WIDTH-1:0] wdata,
    input  logic                                            wvalid,
    input  logic                                            wlast,
    output logic                                            wready,
    output logic [axi_image_bridge_pkg::AXI_ID_WIDTH-1:0]   bid,
    output axi_image_bridge_pkg::axi_resp_e                 bresp,
    output logic                                            bvalid,
    input  logic                                            bready,
    input  logic                                            image_sender_full,
    input  logic                                            dram_buffer_full,
    output logic                                            image_sender_write,
    output logic [axi_image_bridge_pkg::AXI_DATA_WIDTH-1:0] image_sender_fifo_din,
    output logic                                            image_sender_flush,
    output logic                                            set_new_image,
    output logic [axi_image_bridge_pkg::AXI_DATA_WIDTH-1:0] dram_read_data,
    output logic                                            dram_read_data_valid,
    output logic                                            size_write,
    output logic [width_bits-1:0]                           size_width,
    output logic [height_bits-1:0]                          size_height,
    output logic                                            done_write,
    output logic                                            irq_clear
);

    import axi_image_bridge_pkg::*;

    write_state_e             state;
    write_state_e             aw_state;
    logic [AXI_LEN_WIDTH-1:0] beats_left;
    logic                     aw_fire;
    logic                     w_fire;
    logic                     last_beat;

    assign awready = (state == wr_idle);
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    // Burst ends on wlast, or when the awlen count runs out
    assign last_beat = wlast || (beats_left == '0);

    ////////////////////////////////////////////////////////////
    // Address decode and W channel ready
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (wr_reg_e'(awaddr))
            reg_fifo_data:   aw_state = wr_fifo;
            reg_fifo_flush:  aw_state = wr_flush;
            reg_image_size:  aw_state = wr_size;
            reg_dram_done:   aw_state = wr_done;
            reg_dram_buffer: aw_state = wr_buffer;
            reg_new_image:   aw_state = wr_new_image;
            reg_irq_clear:   aw_state = wr_irq_clear;
            default:         aw_state = wr_drain;
        endcase
    end

    always_comb begin
        case (state)
            wr_fifo:          wready = !image_sender_full;
            wr_buffer:        wready = !dram_buffer_full;
            wr_idle, wr_resp: wready = 1'b0;
            default:          wready = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // FSM and B channel
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state  <= wr_idle;
            bvalid <= 1'b0;
            bresp  <= resp_okay;
        end else begin
            case (state)
                wr_idle: begin
                    if (aw_fire) begin
                        state <= aw_state;
                    end
                end
                wr_resp: begin
                    // Hold the response until the master takes it
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= wr_idle;
                    end
                end
                default: begin
                    if (w_fire && last_beat) begin
                        state  <= wr_resp;
                        bvalid <= 1'b1;
                        bresp  <= (state == wr_drain) ? resp_slverr : resp_okay;
                    end
                end
            endcase
        end
    end

    // One-cycle strobes toward the sinks and the status block
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            image_sender_write   <= 1'b0;
            image_sender_flush   <= 1'b0;
            dram_read_data_valid <= 1'b0;
            set_new_image        <= 1'b0;
            size_write           <= 1'b0;
            done_write           <= 1'b0;
            irq_clear            <= 1'b0;
        end else begin
            image_sender_write   <= w_fire && (state == wr_fifo);
            image_sender_flush   <= w_fire && (state == wr_flush) && wdata[0];
            dram_read_data_valid <= w_fire && (state == wr_buffer);
            set_new_image        <= w_fire && last_beat && (state == wr_new_image);
            size_write           <= w_fire && (state == wr_size);
            done_write           <= w_fire && (state == wr_done);
            irq_clear            <= w_fire && last_beat && (state == wr_irq_clear);
        end
    end

    ////////////////////////////////////////////////////////////
    // Burst bookkeeping and data capture
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (aw_fire) begin
            bid        <= awid;
            beats_left <= awlen;
        end else if (w_fire) begin
            beats_left <= beats_left - 1'b1;
        end

        if (w_fire && (state == wr_fifo)) begin
            image_sender_fifo_din <= wdata;
        end
        if (w_fire && (state == wr_buffer)) begin
            dram_read_data <= wdata;
        end
        // Upper bits of each 32-bit field are dropped
        if (w_fire && (state == wr_size)) begin
            size_width  <= wdata[SIZE_WIDTH_LSB +: width_bits];
            size_height <= wdata[SIZE_HEIGHT_LSB +: height_bits];
        end
    end

endmodule

// ==== rtl/read_ctrl.sv ====
`timescale 1ns/1ns

module read_ctrl #(
    parameter int width_bits      = 12,
    parameter int height_bits     = 11,
    parameter int dram_addr_width = 39
) (
    input  logic                                            s_axi_aclk,
    input  logic                                            s_axi_aresetn,
    input  logic [axi_image_bridge_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    input  logic [axi_image_bridge_pkg::AXI_ID_WIDTH-1:0]   arid,
    input  logic [axi_image_bridge_pkg::AXI_LEN_WIDTH-1:0]  arlen,
    input  logic                                            arvalid,
    output logic                                            arready,
    output logic [axi_image_bridge_pkg::AXI_ID_WIDTH-1:0]   rid,
    output logic [axi_image_bridge_pkg::AXI_DATA_WIDTH-1:0] rdata,
    output axi_image_bridge_pkg::axi_resp_e                 rresp,
    output logic                                            rvalid,
    output logic                                            rlast,
    input  logic                                            rready,
    input  logic [dram_addr_width-1:0]                      dram_read_addr,
    input  logic [axi_image_bridge_pkg::AXI_LEN_WIDTH-1:0]  dram_read_len,
    input  logic [width_bits-1:0]                           image_width,
    input  logic [height_bits-1:0]                          image_height
);

    import axi_image_bridge_pkg::*;

    read_state_e               state;
    read_state_e               ar_state;
    read_state_e               load_state;
    logic [AXI_LEN_WIDTH-1:0]  beats_left;
    logic [AXI_DATA_WIDTH-1:0] resolution_word;
    logic [AXI_DATA_WIDTH-1:0] beat_word;
    logic                      ar_fire;
    logic                      r_fire;

    assign arready = (state == rd_idle);
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    always_comb begin
        case (rd_reg_e'(araddr))
            reg_dram_request: ar_state = rd_request;
            reg_resolution:   ar_state = rd_resolution;
            default:          ar_state = rd_error;
        endcase
    end

    // Word for the beat about to be presented
    always_comb begin
        load_state = (state == rd_idle) ? ar_state : state;
        resolution_word = '0;
        resolution_word[SIZE_WIDTH_LSB +: width_bits]   = image_width;
        resolution_word[SIZE_HEIGHT_LSB +: height_bits] = image_height;
        case (load_state)
            rd_request:    beat_word = {64'(dram_read_len), 64'(dram_read_addr)};
            rd_resolution: beat_word = resolution_word;
            default:       beat_word = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Read FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state  <= rd_idle;
            rvalid <= 1'b0;
            rlast  <= 1'b0;
        end else if (ar_fire) begin
            state  <= ar_state;
            rvalid <= 1'b1;
            // Error reply is always a single beat
            rlast  <= (ar_state == rd_error) || (arlen == '0);
        end else if (r_fire) begin
            if (rlast) begin
                state  <= rd_idle;
                rvalid <= 1'b0;
                rlast  <= 1'b0;
            end else begin
                rlast <= (beats_left == AXI_LEN_WIDTH'(1));
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (ar_fire) begin
            rid        <= arid;
            rresp      <= (ar_state == rd_error) ? resp_slverr : resp_okay;
            beats_left <= arlen;
            rdata      <= beat_word;
        end else if (r_fire && !rlast) begin
            beats_left <= beats_left - 1'b1;
            rdata      <= beat_word;
        end
    end

endmodule

// ==== rtl/image_status.sv ====
`timescale 1ns/1ns

module image_status #(
    parameter int width_bits  = 12,
    parameter int height_bits = 11
) (
    input  logic                   s_axi_aclk,
    input  logic                   s_axi_aresetn,
    input  logic                   size_write,
    input  logic [width_bits-1:0]  size_width,
    input  logic [height_bits-1:0] size_height,
    input  logic                   done_write,
    input  logic                   irq_clear,
    input  logic                   dram_read_en,
    output logic [width_bits-1:0]  image_width,
    output logic [height_bits-1:0] image_height,
    output logic                   irq_signal,
    output logic                   dram_read_busy
);

    ////////////////////////////////////////////////////////////
    // Resolution registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            image_width  <= '0;
            image_height <= '0;
        end else if (size_write) begin
            image_width  <= size_width;
            image_height <= size_height;
        end
    end

    ////////////////////////////////////////////////////////////
    // DRAM request flags
    ////////////////////////////////////////////////////////////
    // A new request beats a clear arriving in the same cycle
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            irq_signal     <= 1'b0;
            dram_read_busy <= 1'b0;
        end else begin
            if (dram_read_en) begin
                irq_signal <= 1'b1;
            end else if (irq_clear) begin
                irq_signal <= 1'b0;
            end

            if (dram_read_en) begin
                dram_read_busy <= 1'b1;
            end else if (done_write) begin
                dram_read_busy <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/axi_image_bridge.sv ====
`timescale 1ns/1ns

module axi_image_bridge #(
    parameter int width_bits      = 12,
    parameter int height_bits     = 11,
    parameter int dram_addr_width = 39
) (
    input  logic                                       s_axi_aclk,
    input  logic                                       s_axi_aresetn,

    // AXI write channels
    input  logic [axi_image_bridge_pkg::AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic [axi_image_bridge_pkg::AXI_ID_WIDTH-1:0]   s_axi_awid,
    input  logic [axi_image_bridge_pkg::AXI_LEN_WIDTH-1:0]  s_axi_awlen,
    input  logic                                       s_axi_awvalid,
    output logic                                       s_axi_awready,
    input  logic [axi_image_bridge_pkg::AXI_DATA_WIDTH-1:0] s_axi_wdata,
    input  logic                                       s_axi_wvalid,
    input  logic                                       s_axi_wlast,
    output logic                                       s_axi_wready,
    output logic [axi_image_bridge_pkg::AXI_ID_WIDTH-1:0]   s_axi_bid,
    output axi_image_bridge_pkg::axi_resp_e            s_axi_bresp,
    output logic                                       s_axi_bvalid,
    input  logic                                       s_axi_bready,

    // AXI read channels
    input  logic [axi_image_bridge_pkg::AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic [axi_image_bridge_pkg::AXI_ID_WIDTH-1:0]   s_axi_arid,
    input  logic [axi_image_bridge_pkg::AXI_LEN_WIDTH-1:0]  s_axi_arlen,
    input  logic                                       s_axi_arvalid,
    output logic                                       s_axi_arready,
    output logic [axi_image_bridge_pkg::AXI_ID_WIDTH-1:0]   s_axi_rid,
    output logic [axi_image_bridge_pkg::AXI_DATA_WIDTH-1:0] s_axi_rdata,
    output axi_image_bridge_pkg::axi_resp_e            s_axi_rresp,
    output logic                                       s_axi_rvalid,
    output logic                                       s_axi_rlast,
    input  logic                                       s_axi_rready,

    // Image sender FIFO
    input  logic                                       image_sender_full,
    output logic                                       image_sender_reset,
    output logic                                       image_sender_flush,
    output logic                                       image_sender_write,
    output logic [axi_image_bridge_pkg::AXI_DATA_WIDTH-1:0] image_sender_fifo_din,
    output logic [width_bits-1:0]                      image_width,
    output logic [height_bits-1:0]                     image_height,

    // DRAM request and buffer
    input  logic                                       dram_buffer_full,
    input  logic [dram_addr_width-1:0]                 dram_read_addr,
    input  logic [axi_image_bridge_pkg::AXI_LEN_WIDTH-1:0]  dram_read_len,
    input  logic                                       dram_read_en,
    output logic [axi_image_bridge_pkg::AXI_DATA_WIDTH-1:0] dram_read_data,
    output logic                                       dram_read_data_valid,
    output logic                                       dram_read_busy,
    output logic                                       set_new_image,
    output logic                                       irq_signal
);

    logic                   size_write;
    logic [width_bits-1:0]  size_width;
    logic [height_bits-1:0] size_height;
    logic                   done_write;
    logic                   irq_clear;

    // Sender FIFO is held in reset with the bus
    assign image_sender_reset = ~s_axi_aresetn;

    write_ctrl #(
        .width_bits  (width_bits),
        .height_bits (height_bits)
    ) u_write_ctrl (
        .s_axi_aclk            (s_axi_aclk),
        .s_axi_aresetn         (s_axi_aresetn),
        .awaddr                (s_axi_awaddr),
        .awid                  (s_axi_awid),
        .awlen                 (s_axi_awlen),
        .awvalid               (s_axi_awvalid),
        .awready               (s_axi_awready),
        .wdata                 (s_axi_wdata),
        .wvalid                (s_axi_wvalid),
        .wlast                 (s_axi_wlast),
        .wready                (s_axi_wready),
        .bid                   (s_axi_bid),
        .bresp                 (s_axi_bresp),
        .bvalid                (s_axi_bvalid),
        .bready                (s_axi_bready),
        .image_sender_full     (image_sender_full),
        .dram_buffer_full      (dram_buffer_full),
        .image_sender_write    (image_sender_write),
        .image_sender_fifo_din (image_sender_fifo_din),
        .image_sender_flush    (image_sender_flush),
        .set_new_image         (set_new_image),
        .dram_read_data        (dram_read_data),
        .dram_read_data_valid  (dram_read_data_valid),
        .size_write            (size_write),
        .size_width            (size_width),
        .size_height           (size_height),
        .done_write            (done_write),
        .irq_clear             (irq_clear)
    );

    image_status #(
        .width_bits  (width_bits),
        .height_bits (height_bits)
    ) u_image_status (
        .s_axi_aclk     (s_axi_aclk),
        .s_axi_aresetn  (s_axi_aresetn),
        .size_write     (size_write),
        .size_width     (size_width),
        .size_height    (size_height),
        .done_write     (done_write),
        .irq_clear      (irq_clear),
        .dram_read_en   (dram_read_en),
        .image_width    (image_width),
        .image_height   (image_height),
        .irq_signal     (irq_signal),
        .dram_read_busy (dram_read_busy)
    );

    read_ctrl #(
        .width_bits      (width_bits),
        .height_bits     (height_bits),
        .dram_addr_width (dram_addr_width)
    ) u_read_ctrl (
        .s_axi_aclk     (s_axi_aclk),
        .s_axi_aresetn  (s_axi_aresetn),
        .araddr         (s_axi_araddr),
        .arid           (s_axi_arid),
        .arlen          (s_axi_arlen),
        .arvalid        (s_axi_arvalid),
        .arready        (s_axi_arready),
        .rid            (s_axi_rid),
        .rdata          (s_axi_rdata),
        .rresp          (s_axi_rresp),
        .rvalid         (s_axi_rvalid),
        .rlast          (s_axi_rlast),
        .rready         (s_axi_rready),
        .dram_read_addr (dram_read_addr),
        .dram_read_len  (dram_read_len),
        .image_width    (image_width),
        .image_height   (image_height)
    );

endmodule

// ==== verif/axi_image_bridge_tb.sv ====
`timescale 1ns/1ns

module axi_image_bridge_tb;

    import axi_image_bridge_pkg::*;

    localparam int w_bits    = 12;
    localparam int h_bits    = 11;
    localparam int addr_bits = 39;
    localparam int num_txn   = 47;

    logic s_axi_aclk;
    logic s_axi_aresetn;
    logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr, s_axi_araddr;
    logic [AXI_ID_WIDTH-1:0]   s_axi_awid, s_axi_arid, s_axi_bid, s_axi_rid;
    logic [AXI_LEN_WIDTH-1:0]  s_axi_awlen, s_axi_arlen, dram_read_len;
    logic [AXI_DATA_WIDTH-1:0] s_axi_wdata, s_axi_rdata, image_sender_fifo_din, dram_read_data;
    logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wlast, s_axi_wready;
    logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
    logic s_axi_rvalid, s_axi_rlast, s_axi_rready;
    axi_resp_e s_axi_bresp, s_axi_rresp;
    logic image_sender_full, image_sender_reset, image_sender_flush, image_sender_write;
    logic dram_buffer_full, dram_read_en, dram_read_data_valid, dram_read_busy;
    logic set_new_image, irq_signal;
    logic [w_bits-1:0]    image_width;
    logic [h_bits-1:0]    image_height;
    logic [addr_bits-1:0] dram_read_addr;

    // Reference model state
    logic [AXI_DATA_WIDTH-1:0] exp_fifo[$], got_fifo[$], exp_buf[$], got_buf[$];
    logic [w_bits-1:0]    exp_width;
    logic [h_bits-1:0]    exp_height;
    logic [addr_bits-1:0] req_addr;
    logic [AXI_LEN_WIDTH-1:0] req_len;
    logic exp_irq, exp_busy;
    int   exp_flush, got_flush, exp_new, got_new;
    int   errors, txn_count;
    logic [6:0]  bad_addr;
    logic [31:0] lfsr = 32'hb4be031b;

    axi_image_bridge #(
        .width_bits      (w_bits),
        .height_bits     (h_bits),
        .dram_addr_width (addr_bits)
    ) dut0 (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #20 s_axi_aclk = ~s_axi_aclk;
    end

    ////////////////////////////////////////////////////////////
    // Random source and compare tasks
    ////////////////////////////////////////////////////////////
    function automatic logic rand_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[126:0], rand_bit()};
        end
        return v;
    endfunction

    task automatic check_resp(input axi_resp_e got, input axi_resp_e exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %s expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_data(input logic [AXI_DATA_WIDTH-1:0] got,
                              input logic [AXI_DATA_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_id(input logic [AXI_ID_WIDTH-1:0] got,
                            input logic [AXI_ID_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // Sink monitor, sampled before the edge updates anything
    always @(posedge s_axi_aclk) begin
        if (s_axi_aresetn) begin
            if (image_sender_write) got_fifo.push_back(image_sender_fifo_din);
            if (dram_read_data_valid) got_buf.push_back(dram_read_data);
            if (image_sender_flush) got_flush++;
            if (set_new_image) got_new++;
        end
    end

    initial begin
        repeat (num_txn * 200 + 10) @(posedge s_axi_aclk);
        $display("Watchdog timeout, the DUT stopped answering a handshake");
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////////////////////////
    // One clock with fresh back-pressure on every sink and ready
    task automatic tick();
        @(posedge s_axi_aclk);
        image_sender_full <= rand_bit() & rand_bit();
        dram_buffer_full  <= rand_bit() & rand_bit();
        s_axi_bready      <= rand_bit() | rand_bit();
        s_axi_rready      <= rand_bit() | rand_bit();
    endtask

    task automatic axi_write(input logic [6:0] addr, input logic [7:0] len);
        logic [AXI_ID_WIDTH-1:0]   id;
        logic [AXI_DATA_WIDTH-1:0] data;
        axi_resp_e exp_resp;
        int i;
        txn_count++;
        id = 16'(rand_bits(16));
        exp_resp = resp_okay;
        s_axi_awaddr  <= addr;
        s_axi_awid    <= id;
        s_axi_awlen   <= len;
        s_axi_awvalid <= 1'b1;
        do tick(); while (!(s_axi_awvalid && s_axi_awready));
        s_axi_awvalid <= 1'b0;
        for (i = 0; i <= int'(len); i++) begin
            data = rand_bits(128);
            s_axi_wdata  <= data;
            s_axi_wlast  <= (i == int'(len));
            s_axi_wvalid <= 1'b1;
            do tick(); while (!(s_axi_wvalid && s_axi_wready));
            case (addr)
                reg_fifo_data:   exp_fifo.push_back(data);
                reg_fifo_flush:  if (data[0]) exp_flush++;
                reg_image_size: begin
                    exp_width  = data[32 +: w_bits];
                    exp_height = data[0 +: h_bits];
                end
                reg_dram_done:   exp_busy = 1'b0;
                reg_dram_buffer: exp_buf.push_back(data);
                reg_new_image:   if (i == int'(len)) exp_new++;
                reg_irq_clear:   if (i == int'(len)) exp_irq = 1'b0;
                default:         exp_resp = resp_slverr;
            endcase
        end
        s_axi_wvalid <= 1'b0;
        s_axi_wlast  <= 1'b0;
        do tick(); while (!(s_axi_bvalid && s_axi_bready));
        check_resp(s_axi_bresp, exp_resp, "bresp");
        check_id(s_axi_bid, id, "bid");
        check_sinks();
    endtask

    task automatic check_sinks();
        int i;
        tick();
        check_count(got_fifo.size(), exp_fifo.size(), "image sender writes");
        for (i = 0; i < exp_fifo.size() && i < got_fifo.size(); i++) begin
            check_data(got_fifo[i], exp_fifo[i], "image_sender_fifo_din");
        end
        check_count(got_buf.size(), exp_buf.size(), "DRAM buffer writes");
        for (i = 0; i < exp_buf.size() && i < got_buf.size(); i++) begin
            check_data(got_buf[i], exp_buf[i], "dram_read_data");
        end
        exp_fifo.delete();
        got_fifo.delete();
        exp_buf.delete();
        got_buf.delete();
        check_count(got_flush, exp_flush, "flush pulses");
        check_count(got_new, exp_new, "set_new_image pulses");
        check_flag(irq_signal, exp_irq, "irq_signal");
        check_flag(dram_read_busy, exp_busy, "dram_read_busy");
        check_data(128'(image_width), 128'(exp_width), "image_width");
        check_data(128'(image_height), 128'(exp_height), "image_height");
    endtask

    task automatic axi_read(input logic [6:0] addr, input logic [7:0] len);
        logic [AXI_ID_WIDTH-1:0]   id;
        logic [AXI_DATA_WIDTH-1:0] exp_word;
        axi_resp_e exp_resp;
        int beats;
        int i;
        txn_count++;
        id = 16'(rand_bits(16));
        exp_resp = resp_okay;
        beats = int'(len) + 1;
        case (addr)
            reg_dram_request: exp_word = {64'(req_len), 64'(req_addr)};
            reg_resolution:   exp_word = {64'd0, 32'(exp_width), 32'(exp_height)};
            default: begin
                exp_word = '0;
                exp_resp = resp_slverr;
                beats    = 1;
            end
        endcase
        s_axi_araddr  <= addr;
        s_axi_arid    <= id;
        s_axi_arlen   <= len;
        s_axi_arvalid <= 1'b1;
        do tick(); while (!(s_axi_arvalid && s_axi_arready));
        s_axi_arvalid <= 1'b0;
        for (i = 0; i < beats; i++) begin
            do tick(); while (!(s_axi_rvalid && s_axi_rready));
            check_data(s_axi_rdata, exp_word, "rdata");
            check_resp(s_axi_rresp, exp_resp, "rresp");
            check_id(s_axi_rid, id, "rid");
            check_flag(s_axi_rlast, i == beats - 1, "rlast");
        end
    endtask

    // DRAM read request pulse, then the flags must be up
    task automatic dram_request();
        req_addr = 39'(rand_bits(39));
        req_len  = 8'(rand_bits(8));
        dram_read_addr <= req_addr;
        dram_read_len  <= req_len;
        dram_read_en   <= 1'b1;
        tick();
        dram_read_en <= 1'b0;
        exp_irq  = 1'b1;
        exp_busy = 1'b1;
        tick();
        check_flag(irq_signal, 1'b1, "irq_signal after request");
        check_flag(dram_read_busy, 1'b1, "dram_read_busy after request");
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        s_axi_aresetn = 1'b0;
        {s_axi_awaddr, s_axi_awid, s_axi_awlen, s_axi_awvalid} = '0;
        {s_axi_wdata, s_axi_wvalid, s_axi_wlast, s_axi_bready} = '0;
        {s_axi_araddr, s_axi_arid, s_axi_arlen, s_axi_arvalid, s_axi_rready} = '0;
        {image_sender_full, dram_buffer_full, dram_read_en} = '0;
        dram_read_addr = '0;
        dram_read_len  = '0;
        {exp_width, exp_height, req_addr, req_len, exp_irq, exp_busy} = '0;
        {exp_flush, got_flush, exp_new, got_new, errors, txn_count} = '0;
        repeat (2) @(posedge s_axi_aclk);
        check_flag(image_sender_reset, 1'b1, "image_sender_reset during reset");
        s_axi_aresetn <= 1'b1;
        tick();
        check_flag(image_sender_reset, 1'b0, "image_sender_reset after reset");
        check_flag(s_axi_bvalid, 1'b0, "bvalid after reset");
        check_flag(s_axi_rvalid, 1'b0, "rvalid after reset");
        check_flag(s_axi_rlast, 1'b0, "rlast after reset");
        check_flag(image_sender_write, 1'b0, "image_sender_write after reset");
        check_flag(image_sender_flush, 1'b0, "image_sender_flush after reset");
        check_flag(dram_read_data_valid, 1'b0, "dram_read_data_valid after reset");
        check_flag(set_new_image, 1'b0, "set_new_image after reset");
        check_sinks();

        repeat (8) axi_write(reg_fifo_data, 8'(rand_bits(4)));
        repeat (4) begin
            axi_write(reg_image_size, 8'(rand_bits(2)));
            axi_read(reg_resolution, 8'(rand_bits(4)));
        end
        repeat (4) begin
            dram_request();
            axi_read(reg_dram_request, 8'(rand_bits(4)));
            axi_write(reg_dram_buffer, 8'(rand_bits(4)));
            axi_write(reg_dram_done, 8'd0);
            axi_write(reg_irq_clear, 8'(rand_bits(2)));
        end
        repeat (4) begin
            axi_write(reg_fifo_flush, 8'(rand_bits(4)));
            axi_write(reg_new_image, 8'(rand_bits(2)));
        end
        // Low nibble 8 is never a register address
        bad_addr = (7'(rand_bits(3)) << 4) | 7'h8;
        axi_write(bad_addr, 8'(rand_bits(4)));
        axi_write(7'h70, 8'(rand_bits(4)));
        axi_read(bad_addr, 8'(rand_bits(4)));

        $display("Ran %0d transactions, %0d errors", txn_count, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== axi_image_bridge.f ====
rtl/axi_image_bridge_pkg.sv
rtl/write_ctrl.sv
rtl/read_ctrl.sv
rtl/image_status.sv
rtl/axi_image_bridge.sv
verif/axi_image_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the axi_image_bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module axi_image_bridge_tb \
    -f axi_image_bridge.f -o sim_axi_image_bridge

out=$(./obj_dir/sim_axi_image_bridge)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST OK"
